//--- project.f
clock_pkg.sv
tick_gen.sv
button_sync.sv
clock_ctrl.sv
time_keeper.sv
alarm_unit.sv
seg_encoder.sv
display_scan.sv
digital_clock_top.sv
tb_digital_clock.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_digital_clock
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_digital_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_digital_clock;

	import clock_pkg::*;

	localparam int TICK_DIV  = 64;
	localparam int BLINK_DIV = 16;
	localparam int SCAN_DIV  = 2;
	localparam int TIMEOUT   = 20_000;
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic        clk;
	logic        rst_n;
	btn_t        i_btn;
	seg_t        o_seg;
	logic [5:0]  o_seg_enb;
	logic        o_alarm;

	// reference model state
	int     m_cyc;
	int     m_idx;
	btn_t   m_h1, m_h2, m_h3, m_h4;	// sampled button levels, newest first
	mode_e  m_mode;
	pos_e   m_pos;
	logic   m_en;
	logic   m_alarm;
	logic   m_blink;
	logic   m_scanned;
	seg_t   m_seg;
	time_t  m_time;
	time_t  m_atime;
	int     blank_cnt = 0;
	int     run_cycles = 0;

	digital_clock_top #(
		.TICK_DIV	(TICK_DIV),
		.BLINK_DIV	(BLINK_DIV),
		.SCAN_DIV	(SCAN_DIV)
	) digital_clock_top_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn		(i_btn),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb),
		.o_alarm	(o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// model rules
	// ------------------------------------------------------------
	function automatic unit_t wrap_inc(unit_t v, int lim);
		return (int'(v) >= lim) ? 6'd0 : v + 6'd1;
	endfunction

	function automatic time_t bump_field(time_t t, pos_e p);
		time_t r;
		r = t;
		if (p == POS_SEC) r.sec = wrap_inc(t.sec, 59);
		else if (p == POS_MIN) r.min = wrap_inc(t.min, 59);
		else r.hr = wrap_inc(t.hr, 23);
		return r;
	endfunction

	function automatic time_t tick_time(time_t t);
		time_t r;
		r = t;
		r.sec = wrap_inc(t.sec, 59);
		if (t.sec == 6'd59) begin
			r.min = wrap_inc(t.min, 59);
			if (t.min == 6'd59) r.hr = wrap_inc(t.hr, 23);	// midnight
		end
		return r;
	endfunction

	function automatic int field_of(time_t t, pos_e p);
		if (p == POS_SEC) return int'(t.sec);
		if (p == POS_MIN) return int'(t.min);
		return int'(t.hr);
	endfunction

	function automatic seg_t seg_of(int d);
		case (d)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return 7'b0000000;
		endcase
	endfunction

	// segments expected on display digit idx
	function automatic seg_t frame_seg(mode_e md, pos_e ps, logic blk, time_t t, time_t at,
			int idx);
		time_t shown;
		pos_e  fp;
		int    v;
		shown = (md == MODE_ALARM) ? at : t;
		fp = (idx < 2) ? POS_SEC : (idx < 4) ? POS_MIN : POS_HR;
		if (md != MODE_CLOCK && blk && ps == fp) return 7'b0000000;
		v = field_of(shown, fp);
		return (idx % 2 == 0) ? seg_of(v % 10) : seg_of(v / 10);
	endfunction

	always @(posedge clk) begin
		btn_t p;
		if (!rst_n) begin
			m_cyc = 0;
			m_idx = 5;
			{m_h1, m_h2, m_h3, m_h4} = '0;
			m_mode = MODE_CLOCK;
			m_pos = POS_SEC;
			{m_en, m_alarm, m_blink, m_scanned} = '0;
			m_time = '0;
			m_atime = '0;
		end else begin
			m_cyc = m_cyc + 1;
			p = m_h3 & ~m_h4;	// press lands three edges after sampling
			if (m_cyc % SCAN_DIV == 0) begin
				m_idx = (m_idx == 5) ? 0 : m_idx + 1;
				m_seg = frame_seg(m_mode, m_pos, m_blink, m_time, m_atime, m_idx);
				m_scanned = 1'b1;
				if (m_seg == '0) blank_cnt++;
			end
			if (!m_en) m_alarm = 1'b0;
			else if (m_time == m_atime) m_alarm = 1'b1;
			if (m_cyc % TICK_DIV == 0 && m_mode != MODE_SETUP) m_time = tick_time(m_time);
			else if (p.inc && m_mode == MODE_SETUP) m_time = bump_field(m_time, m_pos);
			if (p.inc && m_mode == MODE_ALARM) m_atime = bump_field(m_atime, m_pos);
			if (p.mode) begin
				case (m_mode)
					MODE_CLOCK: m_mode = MODE_SETUP;
					MODE_SETUP: m_mode = MODE_ALARM;
					default:    m_mode = MODE_CLOCK;
				endcase
			end
			if (p.pos) begin
				case (m_pos)
					POS_SEC: m_pos = POS_MIN;
					POS_MIN: m_pos = POS_HR;
					default: m_pos = POS_SEC;
				endcase
			end
			if (p.alarm) m_en = ~m_en;
			if (m_cyc % BLINK_DIV == 0) m_blink = ~m_blink;
			m_h4 = m_h3;
			m_h3 = m_h2;
			m_h2 = m_h1;
			m_h1 = i_btn;
		end
	end

	// ------------------------------------------------------------
	// checks, sampled mid-cycle
	// ------------------------------------------------------------
	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	always @(negedge clk) begin
		logic [5:0] exp_enb;
		exp_enb = m_scanned ? ~(6'(1) << m_idx) : 6'b111111;
		assert (o_seg_enb === exp_enb) else
			report_error($sformatf("o_seg_enb %b, expected %b", o_seg_enb, exp_enb));
		assert (o_alarm === (rst_n ? m_alarm : 1'b0)) else
			report_error($sformatf("o_alarm %b, expected %b", o_alarm, m_alarm));
		if (rst_n && m_scanned) begin
			assert (o_seg === m_seg) else
				report_error($sformatf("digit %0d shows %b, expected %b",
					m_idx, o_seg, m_seg));
		end
	end

	always @(posedge clk) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= TIMEOUT) begin
			$display("TEST FAILED");
			$fatal(1, "timeout, run did not finish within %0d cycles", TIMEOUT);
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic press_button(input int which);
		btn_t b;
		int   hold;
		int   gap;
		hold = 4 + int'($urandom % 5);
		gap  = 4 + int'($urandom % 9);	// long enough for the press to land
		b = '0;
		case (which)
			BTN_MODE: b.mode = 1'b1;
			BTN_POS:  b.pos = 1'b1;
			BTN_INC:  b.inc = 1'b1;
			default:  b.alarm = 1'b1;
		endcase
		@(posedge clk);
		i_btn <= b;
		repeat (hold) @(posedge clk);
		i_btn <= '0;
		repeat (gap) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic set_mode(input mode_e md);
		while (m_mode != md) press_button(BTN_MODE);
	endtask

	task automatic set_field(input pos_e p, input int value, input bit on_alarm);
		while (m_pos != p) press_button(BTN_POS);
		while (field_of(on_alarm ? m_atime : m_time, p) != value) press_button(BTN_INC);
	endtask

	task automatic random_presses(input int n);
		repeat (n) begin
			if ($urandom % 3 == 0) press_button(BTN_POS);
			else press_button(BTN_INC);
		end
	endtask

	initial begin
		void'($urandom(32'hd9ea));
		rst_n = 1'b0;
		i_btn = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		idle(3 * TICK_DIV);

		// setup, time frozen while ticks pass
		set_mode(MODE_SETUP);
		random_presses(12);
		idle(2 * TICK_DIV);
		set_field(POS_HR, 23, 1'b0);
		set_field(POS_MIN, 59, 1'b0);
		set_field(POS_SEC, 30, 1'b0);

		// alarm edit with the clock running
		set_mode(MODE_ALARM);
		random_presses(8);
		set_mode(MODE_CLOCK);
		while (!(m_time.hr == 6'd0 && m_time.min == 6'd0 && m_time.sec == 6'd2))
			@(negedge clk);

		// alarm at 00:01:00
		set_mode(MODE_ALARM);
		set_field(POS_HR, 0, 1'b1);
		set_field(POS_MIN, 1, 1'b1);
		set_field(POS_SEC, 0, 1'b1);
		set_mode(MODE_SETUP);
		set_field(POS_HR, 0, 1'b0);
		set_field(POS_MIN, 0, 1'b0);
		set_field(POS_SEC, 50, 1'b0);
		set_mode(MODE_CLOCK);
		press_button(BTN_ALARM);
		while (!m_alarm) @(negedge clk);
		idle(2 * TICK_DIV);
		assert (o_alarm === 1'b1) else report_error("o_alarm dropped while enabled");
		press_button(BTN_ALARM);
		assert (o_alarm === 1'b0) else report_error("o_alarm still high after disable");
		idle(20);

		if (blank_cnt > 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "no digit pair was ever blanked during the run");
		end
	end

endmodule

`default_nettype wire

//--- digital_clock_top.sv
`timescale 1ns/1ps
`default_nettype none

module digital_clock_top #(
	parameter int TICK_DIV  = 50_000_000,
	parameter int BLINK_DIV = 12_500_000,
	parameter int SCAN_DIV  = 5_000
) (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire clock_pkg::btn_t               i_btn,
	output wire clock_pkg::seg_t               o_seg,
	output wire [clock_pkg::NUM_DIGITS-1:0]    o_seg_enb,
	output wire                                o_alarm
);

	import clock_pkg::*;

	btn_t    press;
	mode_e   mode;
	pos_e    pos;
	pos_e    inc_pos;
	logic    sec_tick;
	logic    blink;
	logic    scan_step;
	logic    run;
	logic    set_inc;
	logic    alarm_inc;
	logic    alarm_en;
	time_t   cur_time;
	time_t   alarm_time;
	digits_t digits;

	// ------------------------------------------------------------
	// timing and control
	// ------------------------------------------------------------
	tick_gen #(
		.TICK_DIV	(TICK_DIV),
		.BLINK_DIV	(BLINK_DIV),
		.SCAN_DIV	(SCAN_DIV)
	) u_tick_gen (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_sec_tick	(sec_tick),
		.o_blink	(blink),
		.o_scan_step	(scan_step)
	);

	button_sync u_button_sync (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn		(i_btn),
		.o_press	(press)
	);

	clock_ctrl u_clock_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_press	(press),
		.i_sec_tick	(sec_tick),
		.o_mode		(mode),
		.o_pos		(pos),
		.o_run		(run),
		.o_set_inc	(set_inc),
		.o_alarm_inc	(alarm_inc),
		.o_inc_pos	(inc_pos),
		.o_alarm_en	(alarm_en)
	);

	// ------------------------------------------------------------
	// datapath and display
	// ------------------------------------------------------------
	time_keeper u_time_keeper (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_run		(run),
		.i_set_inc	(set_inc),
		.i_inc_pos	(inc_pos),
		.o_time		(cur_time)
	);

	alarm_unit u_alarm_unit (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_alarm_inc	(alarm_inc),
		.i_inc_pos	(inc_pos),
		.i_alarm_en	(alarm_en),
		.i_time		(cur_time),
		.o_alarm_time	(alarm_time),
		.o_alarm	(o_alarm)
	);

	seg_encoder u_seg_encoder (
		.i_mode		(mode),
		.i_pos		(pos),
		.i_blink	(blink),
		.i_time		(cur_time),
		.i_alarm_time	(alarm_time),
		.o_digits	(digits)
	);

	display_scan #(
		.NUM_DIGITS	(NUM_DIGITS)
	) u_display_scan (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_step	(scan_step),
		.i_digits	(digits),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb)
	);

endmodule

`default_nettype wire

//--- display_scan.sv
`timescale 1ns/1ps
`default_nettype none

module display_scan #(
	parameter int NUM_DIGITS = 6
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     i_scan_step,
	input  wire clock_pkg::digits_t i_digits,
	output clock_pkg::seg_t         o_seg,
	output logic [NUM_DIGITS-1:0]   o_seg_enb
);

	import clock_pkg::*;

	localparam int IW    = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;
	localparam int SEG_W = $bits(seg_t);

	logic [IW-1:0] idx;
	logic [IW-1:0] idx_next;

	assign idx_next = (idx == IW'(NUM_DIGITS - 1)) ? '0 : idx + IW'(1);

	// parked on the last digit so the first step lands on digit 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= IW'(NUM_DIGITS - 1);
			o_seg_enb <= '1;
		end else if (i_scan_step) begin
			idx       <= idx_next;
			o_seg_enb <= ~(NUM_DIGITS'(1) << idx_next);	// active low
		end
	end

	always_ff @(posedge clk) begin
		if (i_scan_step) begin
			o_seg <= i_digits[idx_next*SEG_W +: SEG_W];
		end
	end

endmodule

`default_nettype wire

//--- seg_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg_encoder (
	input  wire clock_pkg::mode_e i_mode,
	input  wire clock_pkg::pos_e  i_pos,
	input  wire                   i_blink,
	input  wire clock_pkg::time_t i_time,
	input  wire clock_pkg::time_t i_alarm_time,
	output clock_pkg::digits_t    o_digits
);

	import clock_pkg::*;

	function automatic seg_t seg_decode(digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	time_t shown;
	unit_t field [3];	// sec, min, hr
	seg_t  seg [NUM_DIGITS];
	logic  setting;

	assign shown   = (i_mode == MODE_ALARM) ? i_alarm_time : i_time;
	assign setting = (i_mode != MODE_CLOCK);

	assign field[0] = shown.sec;
	assign field[1] = shown.min;
	assign field[2] = shown.hr;

	// ones on the even digit, tens on the odd one
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			if (setting && i_blink && (int'(i_pos) == i)) begin
				seg[2*i]   = '0;
				seg[2*i+1] = '0;
			end else begin
				seg[2*i]   = seg_decode(digit_t'(field[i] % 10));
				seg[2*i+1] = seg_decode(digit_t'(field[i] / 10));
			end
		end
	end

	assign o_digits = {seg[5], seg[4], seg[3], seg[2], seg[1], seg[0]};

endmodule

`default_nettype wire

//--- alarm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_unit (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   i_alarm_inc,
	input  wire clock_pkg::pos_e  i_inc_pos,
	input  wire                   i_alarm_en,
	input  wire clock_pkg::time_t i_time,
	output clock_pkg::time_t      o_alarm_time,
	output logic                  o_alarm
);

	import clock_pkg::*;

	logic match;

	assign match = (i_time == o_alarm_time);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_time <= '0;
		end else if (i_alarm_inc) begin
			o_alarm_time <= time_inc_field(o_alarm_time, i_inc_pos);
		end
	end

	// latched until the enable goes off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm <= 1'b0;
		end else if (match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- time_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module time_keeper (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_run,
	input  wire                  i_set_inc,
	input  wire clock_pkg::pos_e i_inc_pos,
	output clock_pkg::time_t     o_time
);

	import clock_pkg::*;

	logic sec_wrap;
	logic min_wrap;

	assign sec_wrap = (o_time.sec == SEC_MAX);
	assign min_wrap = (o_time.min == MIN_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (i_run) begin
			o_time.sec <= unit_inc(o_time.sec, SEC_MAX);
			if (sec_wrap) begin
				o_time.min <= unit_inc(o_time.min, MIN_MAX);
				if (min_wrap) begin
					o_time.hr <= unit_inc(o_time.hr, HR_MAX);	// 24h wrap
				end
			end
		end else if (i_set_inc) begin
			o_time <= time_inc_field(o_time, i_inc_pos);
		end
	end

endmodule

`default_nettype wire

//--- clock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire clock_pkg::btn_t i_press,
	input  wire                  i_sec_tick,
	output clock_pkg::mode_e     o_mode,
	output clock_pkg::pos_e      o_pos,
	output logic                 o_run,
	output logic                 o_set_inc,
	output logic                 o_alarm_inc,
	output clock_pkg::pos_e      o_inc_pos,
	output logic                 o_alarm_en
);

	import clock_pkg::*;

	mode_e mode;
	mode_e mode_next;
	pos_e  pos;
	pos_e  pos_next;

	// ------------------------------------------------------------
	// mode and position stepping
	// ------------------------------------------------------------
	always_comb begin
		mode_next = mode;
		if (i_press.mode) begin
			case (mode)
				MODE_CLOCK: mode_next = MODE_SETUP;
				MODE_SETUP: mode_next = MODE_ALARM;
				default:    mode_next = MODE_CLOCK;
			endcase
		end
	end

	always_comb begin
		pos_next = pos;
		if (i_press.pos) begin
			case (pos)
				POS_SEC: pos_next = POS_MIN;
				POS_MIN: pos_next = POS_HR;
				default: pos_next = POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode       <= MODE_CLOCK;
			pos        <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			mode <= mode_next;
			pos  <= pos_next;
			if (i_press.alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// ------------------------------------------------------------
	// enables to the datapath
	// ------------------------------------------------------------
	assign o_mode      = mode;
	assign o_pos       = pos;
	assign o_inc_pos   = pos;
	assign o_run       = i_sec_tick && (mode != MODE_SETUP);	// time frozen in setup
	assign o_set_inc   = i_press.inc && (mode == MODE_SETUP);
	assign o_alarm_inc = i_press.inc && (mode == MODE_ALARM);

endmodule

`default_nettype wire

//--- button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync (
	input  wire             clk,
	input  wire             rst_n,
	input  wire clock_pkg::btn_t i_btn,
	output clock_pkg::btn_t o_press
);

	import clock_pkg::*;

	btn_t sync1;
	btn_t sync2;
	btn_t prev;	// last synchronized level

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1   <= '0;
			sync2   <= '0;
			prev    <= '0;
			o_press <= '0;
		end else begin
			sync1   <= i_btn;
			sync2   <= sync1;
			prev    <= sync2;
			o_press <= sync2 & ~prev;	// rising edge only
		end
	end

endmodule

`default_nettype wire

//--- tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int TICK_DIV  = 50_000_000,
	parameter int BLINK_DIV = 12_500_000,
	parameter int SCAN_DIV  = 5_000
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_sec_tick,
	output logic o_blink,
	output logic o_scan_step
);

	localparam int MAX_TB  = (TICK_DIV > BLINK_DIV) ? TICK_DIV : BLINK_DIV;
	localparam int MAX_DIV = (MAX_TB > SCAN_DIV) ? MAX_TB : SCAN_DIV;
	localparam int CW      = (MAX_DIV > 1) ? $clog2(MAX_DIV) : 1;

	// 0 second, 1 blink, 2 scan
	localparam int DIV [3] = '{TICK_DIV, BLINK_DIV, SCAN_DIV};

	logic [CW-1:0] cnt [3];
	logic [2:0]    hit;

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			hit[i] = (cnt[i] == '0);
		end
	end

	// down-counters, reload on zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++) begin
				cnt[i] <= CW'(DIV[i] - 1);
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				cnt[i] <= hit[i] ? CW'(DIV[i] - 1) : cnt[i] - CW'(1);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_blink <= 1'b0;
		end else if (hit[1]) begin
			o_blink <= ~o_blink;
		end
	end

	assign o_sec_tick  = hit[0];	// last cycle of each second
	assign o_scan_step = hit[2];

endmodule

`default_nettype wire

//--- clock_pkg.sv
`default_nettype none

package clock_pkg;

	typedef logic [5:0] unit_t;	// one time field, 0..59
	typedef logic [3:0] digit_t;
	typedef logic [6:0] seg_t;	// {a,b,c,d,e,f,g}, active high

	localparam unit_t SEC_MAX    = 6'd59;
	localparam unit_t MIN_MAX    = 6'd59;
	localparam unit_t HR_MAX     = 6'd23;
	localparam int    NUM_DIGITS = 6;

	typedef struct packed {
		unit_t hr;
		unit_t min;
		unit_t sec;
	} time_t;

	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} btn_t;

	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SETUP,
		MODE_ALARM
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_e;

	typedef struct packed {
		seg_t d5;
		seg_t d4;
		seg_t d3;
		seg_t d2;
		seg_t d1;
		seg_t d0;
	} digits_t;

	function automatic unit_t unit_inc(unit_t val, unit_t max);
		return (val >= max) ? '0 : val + 6'd1;
	endfunction

	// setup step of one field, no carry into the next
	function automatic time_t time_inc_field(time_t t, pos_e pos);
		time_t r;
		r = t;
		case (pos)
			POS_SEC: r.sec = unit_inc(t.sec, SEC_MAX);
			POS_MIN: r.min = unit_inc(t.min, MIN_MAX);
			default: r.hr  = unit_inc(t.hr, HR_MAX);
		endcase
		return r;
	endfunction

endpackage

`default_nettype wire
